//--- common/excPkg.sv
package excPkg;

    ////////////////////
    // Global sizes and addresses
    ////////////////////

    // Hardware interrupt lines into CP0
    localparam int NUM_HW_INT = 6;

    // Timer windows on the system bus, 16 bytes each
    localparam logic [31:0] TIMER0_BASE = 32'h0000_7F00;
    localparam logic [31:0] TIMER1_BASE = 32'h0000_7F10;

    ////////////////////
    // Coprocessor 0
    ////////////////////

    // CP0 register numbers used by mtc0 / mfc0
    typedef enum logic [4:0] {
        CP0_SR    = 5'd12,
        CP0_CAUSE = 5'd13,
        CP0_EPC   = 5'd14
    } cp0RegT;

    // Exception codes as stored in Cause.ExcCode
    // EXC_INT doubles as "nothing reported"
    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } excCodeT;

    // One coprocessor move from the pipeline
    typedef struct packed {
        logic        en;
        cp0RegT      addr;
        logic [31:0] wdata;
    } cp0MoveT;

    // Exception report from the pipeline
    typedef struct packed {
        logic [31:0] vpc;
        logic        bd;
        excCodeT     code;
    } excInfoT;

    ////////////////////
    // System bus and timers
    ////////////////////

    // Single-cycle bus access, no handshake
    typedef struct packed {
        logic        valid;
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } busReqT;

    // Word index inside a timer window (byte offsets 0, 4, 8)
    typedef enum logic [1:0] {
        TREG_CTRL   = 2'd0,
        TREG_PRESET = 2'd1,
        TREG_COUNT  = 2'd2
    } timerRegT;

    // Timer FSM
    typedef enum logic [1:0] {
        TS_IDLE,
        TS_LOAD,
        TS_COUNT,
        TS_IRQ
    } timerStateT;

endpackage

//--- cp0/cp0.sv
`timescale 1ns/1ps

module cp0 (
    input  logic                          clk,
    input  logic                          reset,
    input  excPkg::cp0MoveT               move,
    input  excPkg::excInfoT               exc,
    input  logic                          eretClr,
    input  logic [excPkg::NUM_HW_INT-1:0] hwInt,
    output logic [31:0]                   cp0Rdata,
    output logic [31:0]                   epc,
    output logic                          excReq
);

    ////////////////////
    // Register field positions
    ////////////////////

    // SR fields
    localparam int IE_BIT  = 0;
    localparam int EXL_BIT = 1;
    localparam int IM_LSB  = 10;

    // Cause fields
    localparam int CODE_LSB = 2;
    localparam int CODE_W   = 5;
    localparam int IP_LSB   = 10;
    localparam int BD_BIT   = 31;

    // Architectural registers
    logic [31:0] sr;
    logic [31:0] cause;
    logic [31:0] epcReg;

    // Decoded SR fields
    logic                          exl;
    logic                          ie;
    logic [excPkg::NUM_HW_INT-1:0] im;

    // Request terms
    logic        excPending;
    logic        intReq;
    logic [31:0] victimPc;

    assign exl = sr[EXL_BIT];
    assign ie  = sr[IE_BIT];
    assign im  = sr[IM_LSB +: excPkg::NUM_HW_INT];

    ////////////////////
    // Request decision
    ////////////////////

    // Pipeline reported a real exception
    assign excPending = (exc.code != excPkg::EXC_INT);

    // Enabled hardware interrupt, masked by IM and IE
    assign intReq = !exl && ie && (|(hwInt & im));

    // Nothing is taken while already in exception level
    assign excReq = (!exl && excPending) || intReq;

    // Delay-slot victim restarts at the branch
    assign victimPc = exc.bd ? (exc.vpc - 32'd4) : exc.vpc;

    ////////////////////
    // Register updates
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            sr     <= 32'd0;
            cause  <= 32'd0;
            epcReg <= 32'd0;
        end else begin
            // Pending lines mirrored every cycle
            cause[IP_LSB +: excPkg::NUM_HW_INT] <= hwInt;

            // Return from exception
            if (eretClr) begin
                sr[EXL_BIT] <= 1'b0;
            end

            if (excReq) begin
                // Entry into the handler
                epcReg          <= victimPc;
                cause[BD_BIT]   <= exc.bd;
                // Interrupt has priority over a same-cycle exception
                cause[CODE_LSB +: CODE_W] <= intReq ? excPkg::EXC_INT : exc.code;
                sr[EXL_BIT]     <= 1'b1;
            end else if (move.en) begin
                // mtc0, only SR and EPC writable
                case (move.addr)
                    excPkg::CP0_SR: begin
                        sr <= move.wdata;
                    end
                    excPkg::CP0_EPC: begin
                        epcReg <= move.wdata;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    ////////////////////
    // Move-from path
    ////////////////////

    // Same-cycle write data forwarded to the reader
    always_comb begin
        case (move.addr)
            excPkg::CP0_SR:    cp0Rdata = move.en ? move.wdata : sr;
            excPkg::CP0_CAUSE: cp0Rdata = move.en ? move.wdata : cause;
            excPkg::CP0_EPC:   cp0Rdata = move.en ? move.wdata : epcReg;
            default:           cp0Rdata = 32'd0;
        endcase
    end

    // Return address for eret
    assign epc = epcReg;

endmodule

//--- hdl/timer.sv
`timescale 1ns/1ps

module timer #(
    parameter logic [31:0] BASE = excPkg::TIMER0_BASE
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             we,
    input  excPkg::timerRegT regSel,
    input  logic [31:0]      wdata,
    output logic [31:0]      rdata,
    output logic             irq
);

    ////////////////////
    // CTRL layout
    ////////////////////

    localparam int         EN_BIT      = 0;
    localparam int         MODE_LSB    = 1;
    localparam int         IM_BIT      = 3;
    localparam logic [1:0] MODE_RELOAD = 2'd1;

    // Timer registers
    logic [3:0]  ctrl;
    logic [31:0] preset;
    logic [31:0] count;

    excPkg::timerStateT state;

    // Mode 1 reloads, anything else is one-shot
    logic autoReload;

    assign autoReload = (ctrl[MODE_LSB +: 2] == MODE_RELOAD);

    ////////////////////
    // Counter FSM and register writes
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl   <= 4'd0;
            preset <= 32'd0;
            count  <= 32'd0;
            irq    <= 1'b0;
            state  <= excPkg::TS_IDLE;
        end else begin
            case (state)
                excPkg::TS_IDLE: begin
                    // Start once enabled
                    if (ctrl[EN_BIT]) begin
                        state <= excPkg::TS_COUNT;
                    end
                end
                excPkg::TS_LOAD: begin
                    // Copy new preset into the counter
                    count <= preset;
                    state <= ctrl[EN_BIT] ? excPkg::TS_COUNT : excPkg::TS_IDLE;
                end
                excPkg::TS_COUNT: begin
                    if (!ctrl[EN_BIT]) begin
                        state <= excPkg::TS_IDLE;
                    end else if (count != 32'd0) begin
                        count <= count - 32'd1;
                    end else begin
                        // Expired, fire if unmasked
                        irq   <= ctrl[IM_BIT];
                        state <= excPkg::TS_IRQ;
                        if (autoReload) begin
                            count <= preset;
                        end else begin
                            ctrl[EN_BIT] <= 1'b0;
                        end
                    end
                end
                excPkg::TS_IRQ: begin
                    // Auto-reload drops irq after one cycle
                    if (autoReload) begin
                        irq   <= 1'b0;
                        state <= excPkg::TS_COUNT;
                    end
                    // One-shot parks here until CTRL is written
                end
                default: begin
                    state <= excPkg::TS_IDLE;
                end
            endcase

            // Bus writes override the FSM
            if (we) begin
                case (regSel)
                    excPkg::TREG_CTRL: begin
                        // Acknowledge and restart from idle
                        ctrl  <= wdata[3:0];
                        irq   <= 1'b0;
                        state <= excPkg::TS_IDLE;
                    end
                    excPkg::TREG_PRESET: begin
                        preset <= wdata;
                        state  <= excPkg::TS_LOAD;
                    end
                    default: begin
                        // COUNT is read-only
                    end
                endcase
            end
        end
    end

    ////////////////////
    // Read path
    ////////////////////

    // Spare slot at offset 12 returns the base as an ID
    always_comb begin
        case (regSel)
            excPkg::TREG_CTRL:   rdata = {28'd0, ctrl};
            excPkg::TREG_PRESET: rdata = preset;
            excPkg::TREG_COUNT:  rdata = count;
            default:             rdata = BASE;
        endcase
    end

endmodule

//--- hdl/sysBridge.sv
`timescale 1ns/1ps

module sysBridge #(
    parameter logic [31:0] T0_BASE = excPkg::TIMER0_BASE,
    parameter logic [31:0] T1_BASE = excPkg::TIMER1_BASE
) (
    input  excPkg::busReqT   bus,
    input  logic [31:0]      t0Rdata,
    input  logic [31:0]      t1Rdata,
    output logic             t0We,
    output logic             t1We,
    output excPkg::timerRegT regSel,
    output logic [31:0]      wdata,
    output logic [31:0]      busRdata
);

    ////////////////////
    // Address decode
    ////////////////////

    // Each timer owns a 16-byte window
    localparam int WIN_LSB = 4;

    logic hit0;
    logic hit1;
    logic wrAccess;

    // Compare upper bits only
    assign hit0 = bus.valid && (bus.addr[31:WIN_LSB] == T0_BASE[31:WIN_LSB]);
    assign hit1 = bus.valid && (bus.addr[31:WIN_LSB] == T1_BASE[31:WIN_LSB]);

    assign wrAccess = bus.valid && bus.we;

    ////////////////////
    // Write steering
    ////////////////////

    // One strobe at most, misses write nothing
    assign t0We = wrAccess && hit0;
    assign t1We = wrAccess && hit1;

    // Word index inside the window, byte lanes ignored
    assign regSel = excPkg::timerRegT'(bus.addr[3:2]);

    // Shared write data to both timers
    assign wdata = bus.wdata;

    ////////////////////
    // Read mux
    ////////////////////

    // Unmapped or idle bus reads zero
    always_comb begin
        if (hit0) begin
            busRdata = t0Rdata;
        end else if (hit1) begin
            busRdata = t1Rdata;
        end else begin
            busRdata = 32'd0;
        end
    end

endmodule

//--- hdl/excSubsystem.sv
`timescale 1ns/1ps

module excSubsystem #(
    parameter logic [31:0] T0_BASE = excPkg::TIMER0_BASE,
    parameter logic [31:0] T1_BASE = excPkg::TIMER1_BASE
) (
    input  logic            clk,
    input  logic            reset,
    input  excPkg::cp0MoveT move,
    input  excPkg::excInfoT exc,
    input  logic            eretClr,
    input  excPkg::busReqT  bus,
    input  logic [3:0]      extInt,
    output logic [31:0]     cp0Rdata,
    output logic [31:0]     epc,
    output logic            excReq,
    output logic [31:0]     busRdata
);

    // Bridge to timer wiring
    logic             t0We;
    logic             t1We;
    excPkg::timerRegT regSel;
    logic [31:0]      timerWdata;
    logic [31:0]      t0Rdata;
    logic [31:0]      t1Rdata;

    // Interrupt sources
    logic                          t0Irq;
    logic                          t1Irq;
    logic [excPkg::NUM_HW_INT-1:0] hwInt;

    // Timers on lines 0 and 1, pins on lines 2 to 5
    assign hwInt = {extInt, t1Irq, t0Irq};

    ////////////////////
    // Coprocessor 0
    ////////////////////

    cp0 cp0Unit (
        .clk      (clk),
        .reset    (reset),
        .move     (move),
        .exc      (exc),
        .eretClr  (eretClr),
        .hwInt    (hwInt),
        .cp0Rdata (cp0Rdata),
        .epc      (epc),
        .excReq   (excReq)
    );

    ////////////////////
    // System bus
    ////////////////////

    sysBridge #(
        .T0_BASE (T0_BASE),
        .T1_BASE (T1_BASE)
    ) bridge (
        .bus      (bus),
        .t0Rdata  (t0Rdata),
        .t1Rdata  (t1Rdata),
        .t0We     (t0We),
        .t1We     (t1We),
        .regSel   (regSel),
        .wdata    (timerWdata),
        .busRdata (busRdata)
    );

    // Timer 0 drives hwInt[0]
    timer #(
        .BASE (T0_BASE)
    ) timer0 (
        .clk    (clk),
        .reset  (reset),
        .we     (t0We),
        .regSel (regSel),
        .wdata  (timerWdata),
        .rdata  (t0Rdata),
        .irq    (t0Irq)
    );

    // Timer 1 drives hwInt[1]
    timer #(
        .BASE (T1_BASE)
    ) timer1 (
        .clk    (clk),
        .reset  (reset),
        .we     (t1We),
        .regSel (regSel),
        .wdata  (timerWdata),
        .rdata  (t1Rdata),
        .irq    (t1Irq)
    );

endmodule

//--- verif/cp0_checker.sv
`timescale 1ns/1ps

module cp0Checker (
    input logic clk,
    input logic reset,
    input logic excReq,
    input logic exl,
    input logic eretClr,
    input logic srWrite,
    input logic srExl
);

    ////////////////////
    // Expected exception level
    ////////////////////

    // EXL as entry, return and SR writes leave it
    logic exlModel;

    always_ff @(posedge clk) begin
        if (reset) begin
            exlModel <= 1'b0;
        end else if (excReq) begin
            // Entry wins over a same-cycle move or return
            exlModel <= 1'b1;
        end else if (srWrite) begin
            exlModel <= srExl;
        end else if (eretClr) begin
            exlModel <= 1'b0;
        end
    end

    ////////////////////
    // CP0 request rules
    ////////////////////

    // No new request while the handler runs
    property reqBlockedInExl;
        @(posedge clk) disable iff (reset) exlModel |-> !excReq;
    endproperty

    // Taken request enters exception level
    property exlAfterReq;
        @(posedge clk) disable iff (reset) excReq |=> exl;
    endproperty

    // Quiet once reset has been applied for an edge
    property quietInReset;
        @(posedge clk) (reset ##1 reset) |-> !excReq;
    endproperty

    assert property (reqBlockedInExl) else $error("excReq high while EXL is set");
    assert property (exlAfterReq) else $error("EXL not set one cycle after excReq");
    assert property (quietInReset) else $error("excReq high during reset");

endmodule

// Attached to every cp0 instance
bind cp0 cp0Checker cp0Assertions (
    .clk     (clk),
    .reset   (reset),
    .excReq  (excReq),
    .exl     (exl),
    .eretClr (eretClr),
    .srWrite (move.en && (move.addr == excPkg::CP0_SR)),
    .srExl   (move.wdata[1])
);

//--- verif/excSubsystemTb.sv
`timescale 1ns/1ps

module excSubsystemTb;

    // Run length bounds
    localparam int unsigned RESET_CYCLES = 10;
    localparam int unsigned SLACK_CYCLES = 200;

    // DUT signals
    logic            clk;
    logic            reset;
    excPkg::cp0MoveT move;
    excPkg::excInfoT exc;
    logic            eretClr;
    excPkg::busReqT  bus;
    logic [3:0]      extInt;
    logic [31:0]     cp0Rdata;
    logic [31:0]     epc;
    logic            excReq;
    logic [31:0]     busRdata;

    // Parsed trace, one entry per operation
    string       opList[$];
    logic [31:0] argA[$];
    logic [31:0] argB[$];
    logic [31:0] argC[$];
    logic [31:0] argD[$];
    logic [31:0] argE[$];
    logic [31:0] argF[$];

    // Watchdog state
    int unsigned cycleLimit;
    int unsigned cycleCount;
    bit          limitReady;

    excSubsystem #(
        .T0_BASE (excPkg::TIMER0_BASE),
        .T1_BASE (excPkg::TIMER1_BASE)
    ) i_dut (
        .clk      (clk),
        .reset    (reset),
        .move     (move),
        .exc      (exc),
        .eretClr  (eretClr),
        .bus      (bus),
        .extInt   (extInt),
        .cp0Rdata (cp0Rdata),
        .epc      (epc),
        .excReq   (excReq),
        .busRdata (busRdata)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // Failure and compare tasks
    ////////////////////

    task automatic abortRun();
        $display("TEST FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkCp0(input excPkg::cp0RegT regNum, input logic [31:0] expected);
        if (cp0Rdata !== expected) begin
            $display("[FAIL] %0t ns: cp0Rdata (%s) expected %08h, got %08h",
                     $time, regNum.name(), expected, cp0Rdata);
            abortRun();
        end
    endtask

    task automatic checkEpc(input logic [31:0] expected);
        if (epc !== expected) begin
            $display("[FAIL] %0t ns: epc expected %08h, got %08h", $time, expected, epc);
            abortRun();
        end
    endtask

    task automatic checkReq(input logic expected);
        if (excReq !== expected) begin
            $display("[FAIL] %0t ns: excReq expected %0b, got %0b", $time, expected, excReq);
            abortRun();
        end
    endtask

    task automatic checkBus(input logic [31:0] expected);
        if (busRdata !== expected) begin
            $display("[FAIL] %0t ns: busRdata expected %08h, got %08h",
                     $time, expected, busRdata);
            abortRun();
        end
    endtask

    ////////////////////
    // Pipeline-side drivers
    ////////////////////

    // All strobes low, no exception, bus idle
    task automatic driveIdle();
        move    <= '0;
        exc     <= '0;
        eretClr <= 1'b0;
        bus     <= '0;
        extInt  <= 4'd0;
    endtask

    // mtc0, forwarded value seen in the same cycle
    task automatic issueMove(input excPkg::cp0RegT regNum, input logic [31:0] wdata,
                             input logic [31:0] expected);
        @(posedge clk);
        driveIdle();
        move.en    <= 1'b1;
        move.addr  <= regNum;
        move.wdata <= wdata;
        @(negedge clk);
        checkCp0(regNum, expected);
    endtask

    // mfc0 with no write pending
    task automatic readCp0(input excPkg::cp0RegT regNum, input logic [31:0] expected);
        @(posedge clk);
        driveIdle();
        move.addr <= regNum;
        @(negedge clk);
        checkCp0(regNum, expected);
    endtask

    // Report cycle then one idle cycle for the EPC result
    task automatic reportExc(input logic [31:0] vpc, input logic bd, input excPkg::excCodeT code,
                             input logic [3:0] pins, input logic expReq,
                             input logic [31:0] expEpc);
        @(posedge clk);
        driveIdle();
        exc.vpc  <= vpc;
        exc.bd   <= bd;
        exc.code <= code;
        extInt   <= pins;
        @(negedge clk);
        checkReq(expReq);
        @(posedge clk);
        driveIdle();
        @(negedge clk);
        checkEpc(expEpc);
    endtask

    task automatic returnFromExc();
        @(posedge clk);
        driveIdle();
        eretClr <= 1'b1;
    endtask

    task automatic storeWord(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        driveIdle();
        bus.valid <= 1'b1;
        bus.we    <= 1'b1;
        bus.addr  <= addr;
        bus.wdata <= data;
    endtask

    task automatic loadWord(input logic [31:0] addr, input logic [31:0] expected);
        @(posedge clk);
        driveIdle();
        bus.valid <= 1'b1;
        bus.addr  <= addr;
        @(negedge clk);
        checkBus(expected);
    endtask

    // Poll excReq, bounded by the trace's cycle budget
    task automatic awaitReq(input int unsigned maxCycles, input logic expected);
        int unsigned waited;
        bit          seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < maxCycles) begin
            @(posedge clk);
            driveIdle();
            @(negedge clk);
            waited = waited + 1;
            if (excReq === expected) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("excReq never reached %0b within %0d cycles", expected, maxCycles);
            abortRun();
        end
    endtask

    ////////////////////
    // Trace loading
    ////////////////////

    // Clock cycles one trace operation takes
    function automatic int unsigned opCycles(input string opWord, input logic [31:0] a);
        int unsigned cycles;
        cycles = 1;
        if (opWord == "EXC") begin
            cycles = 2;
        end else if (opWord == "WAIT") begin
            cycles = a;
        end
        return cycles;
    endfunction

    task automatic loadTrace();
        int          fd;
        int          fields;
        int unsigned traceCycles;
        string       lineText;
        string       opWord;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] f;
        traceCycles = 0;
        fd = $fopen("verif/excTrace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file verif/excTrace.txt");
            abortRun();
        end
        while (!$feof(fd)) begin
            lineText = "";
            opWord   = "";
            fields   = $fgets(lineText, fd);
            fields   = $sscanf(lineText, "%s %h %h %h %h %h %h", opWord, a, b, c, d, e, f);
            // Blank and comment lines
            if (fields <= 0 || opWord.substr(0, 0) == "#") begin
                continue;
            end
            if (fields != 7) begin
                $display("Trace line has %0d fields instead of 7: %s", fields, lineText);
                abortRun();
            end
            opList.push_back(opWord);
            argA.push_back(a);
            argB.push_back(b);
            argC.push_back(c);
            argD.push_back(d);
            argE.push_back(e);
            argF.push_back(f);
            traceCycles = traceCycles + opCycles(opWord, a);
        end
        $fclose(fd);
        cycleLimit = RESET_CYCLES + traceCycles + SLACK_CYCLES;
        limitReady = 1'b1;
    endtask

    ////////////////////
    // Watchdog
    ////////////////////

    initial begin
        cycleCount = 0;
        wait (limitReady);
        forever begin
            @(posedge clk);
            cycleCount = cycleCount + 1;
            if (cycleCount > cycleLimit) begin
                $display("Timeout, the run went past %0d cycles", cycleLimit);
                abortRun();
            end
        end
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        reset      = 1'b1;
        move       = '0;
        exc        = '0;
        eretClr    = 1'b0;
        bus        = '0;
        extInt     = 4'd0;
        limitReady = 1'b0;
        loadTrace();

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkReq(1'b0);

        for (int idx = 0; idx < opList.size(); idx++) begin
            if (opList[idx] == "MOVE") begin
                issueMove(excPkg::cp0RegT'(argA[idx][4:0]), argB[idx], argF[idx]);
            end else if (opList[idx] == "READ") begin
                readCp0(excPkg::cp0RegT'(argA[idx][4:0]), argF[idx]);
            end else if (opList[idx] == "EXC") begin
                reportExc(argA[idx], argB[idx][0], excPkg::excCodeT'(argC[idx][4:0]),
                          argD[idx][3:0], argE[idx][0], argF[idx]);
            end else if (opList[idx] == "ERET") begin
                returnFromExc();
            end else if (opList[idx] == "BUSW") begin
                storeWord(argA[idx], argB[idx]);
            end else if (opList[idx] == "BUSR") begin
                loadWord(argA[idx], argF[idx]);
            end else if (opList[idx] == "WAIT") begin
                awaitReq(argA[idx], argE[idx][0]);
            end else begin
                $display("Unknown trace opcode %s at entry %0d", opList[idx], idx);
                abortRun();
            end
        end

        // Let the last operation settle
        @(posedge clk);
        driveIdle();
        repeat (2) @(posedge clk);
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- verif/excTrace.txt
# cols: op a b c d e f, hex; MOVE/READ a=reg b=wdata f=cp0Rdata; BUSW a=addr b=wdata
# EXC a=vpc b=bd c=code d=extInt e=excReq f=epc; BUSR a=addr f=busRdata; WAIT a=cycles e=excReq
# SR move and read back, with forwarding
MOVE 0c 00001000 0 0 0 00001000
READ 0c 0 0 0 0 00001000
READ 0d 0 0 0 0 00000000
READ 0e 0 0 0 0 00000000
# Reserved instruction in a delay slot
EXC 00400104 1 0a 0 1 00400100
READ 0d 0 0 0 0 80000028
READ 0c 0 0 0 0 00001002
# Blocked while EXL is set, taken after eret
EXC 00400200 0 0c 0 0 00400100
ERET 0 0 0 0 0 0
EXC 00400200 0 0c 0 1 00400200
READ 0d 0 0 0 0 00000030
ERET 0 0 0 0 0 0
# Pin interrupt wins over a same-cycle overflow
MOVE 0c 00001001 0 0 0 00001001
EXC 00400300 0 0c 1 1 00400300
READ 0d 0 0 0 0 00000000
READ 0c 0 0 0 0 00001003
ERET 0 0 0 0 0 0
# Bus decode, preset load with the timer disabled
BUSR 00008000 0 0 0 0 00000000
BUSW 00007f04 00000005 0 0 0 0
BUSR 00007f04 0 0 0 0 00000005
BUSR 00007f08 0 0 0 0 00000005
BUSR 00007f14 0 0 0 0 00000000
# One-shot timer 0 on hwInt line 0
MOVE 0c 00000401 0 0 0 00000401
BUSW 00007f00 00000009 0 0 0 0
WAIT 00000040 0 0 0 1 0
READ 0d 0 0 0 0 00000400
READ 0c 0 0 0 0 00000403
BUSR 00007f00 0 0 0 0 00000008
BUSW 00007f00 00000000 0 0 0 0
ERET 0 0 0 0 0 0
READ 0d 0 0 0 0 00000000
READ 0c 0 0 0 0 00000401
# Address error in a delay slot after return
EXC 00400404 1 04 0 1 00400400
READ 0d 0 0 0 0 80000010
ERET 0 0 0 0 0 0

//--- project.f
common/excPkg.sv
cp0/cp0.sv
hdl/timer.sv
hdl/sysBridge.sv
hdl/excSubsystem.sv
verif/cp0_checker.sv
verif/excSubsystemTb.sv
